/* include/ramio_consts.svh */
`ifndef RAMIO_CONSTS_SVH
`define RAMIO_CONSTS_SVH

// ---------------------------------------------------------------------------
// burst ram and cache geometry
// ---------------------------------------------------------------------------
`define RAMIO_RAM_ADDR_BITS 21      // byte address into burst ram
`define RAMIO_LINE_INDEX_BITS 4     // 16 lines
`define RAMIO_LINE_OFFSET_BITS 3    // 8 bytes per line
`define RAMIO_BR_CMD_GAP 2          // idle cycles after each cmd_en

// ---------------------------------------------------------------------------
// memory mapped i/o
// ---------------------------------------------------------------------------
`define RAMIO_UART_ADDR 32'hFFFF_FFFF
`define RAMIO_LED_ADDR 32'hFFFF_FFFE
`define RAMIO_UART_CLKS_PER_BIT 8

`endif

/* verilog/ramio_pkg.sv */
`include "ramio_consts.svh"

package ramio_pkg;

  typedef enum logic [1:0] {
    wr_none = 2'd0,
    wr_byte = 2'd1,
    wr_half = 2'd2,
    wr_word = 2'd3
  } write_type_e;

  // plain byte/half reads sign extend, _u forms zero extend
  typedef enum logic [2:0] {
    rd_none   = 3'd0,
    rd_byte   = 3'd1,
    rd_half   = 3'd2,
    rd_word   = 3'd3,
    rd_byte_u = 3'd4,
    rd_half_u = 3'd5
  } read_type_e;

  typedef enum logic [2:0] {
    st_idle,
    st_lookup,
    st_evict,
    st_fill_req,
    st_fill_wait,
    st_done
  } cache_state_e;

  typedef struct packed {
    logic write;
    logic read;
    logic [`RAMIO_RAM_ADDR_BITS-1:0] addr;
    logic [31:0] wdata;    // already on its byte lanes
    logic [3:0] byte_en;
  } cache_req_t;

  typedef struct packed {
    logic cmd;             // 0 read, 1 write
    logic cmd_en;
    logic [`RAMIO_RAM_ADDR_BITS-1:0] addr;
    logic [63:0] wr_data;
    logic [7:0] data_mask;
  } br_cmd_t;

  typedef struct packed {
    logic [63:0] rd_data;
    logic rd_data_valid;
  } br_rsp_t;

endpackage

/* verilog/ramio_decoder.sv */
`include "ramio_consts.svh"

module ramio_decoder (
  input wire clk,
  input wire reset,
  input wire enable,
  input ramio_pkg::write_type_e write_type,
  input ramio_pkg::read_type_e read_type,
  input wire [31:0] address,
  input wire [31:0] data_in,
  output logic [31:0] data_out,
  output logic data_out_ready,
  output logic busy,
  output logic [3:0] led,
  output ramio_pkg::cache_req_t cache_req,
  input wire cache_done,
  input wire [31:0] cache_rdata,
  output logic tx_start,
  output logic [7:0] tx_byte,
  input wire tx_busy
);

  import ramio_pkg::*;

  typedef enum logic [1:0] {dec_idle, dec_ram, dec_uart, dec_misc} dec_state_e;

  dec_state_e state;
  logic [1:0] addr_lo_q;
  read_type_e rtype_q;
  logic accept;
  logic is_io;
  logic is_uart;
  logic is_led;
  logic is_write;
  logic is_read;

  // pick lane from the aligned word and extend
  function automatic logic [31:0] extend(input logic [31:0] word, input logic [1:0] lo,
                                         input read_type_e rt);
    logic [7:0] b;
    logic [15:0] h;
    b = word[{lo, 3'b000} +: 8];
    h = word[{lo[1], 4'b0000} +: 16];
    case (rt)
      rd_byte:   return {{24{b[7]}}, b};
      rd_byte_u: return {24'b0, b};
      rd_half:   return {{16{h[15]}}, h};
      rd_half_u: return {16'b0, h};
      rd_word:   return word;
      default:   return '0;
    endcase
  endfunction

  assign busy = state != dec_idle;
  assign accept = enable && !busy;
  assign is_io = address[31:24] == 8'hFF;   // anything else goes to ram
  assign is_uart = address == `RAMIO_UART_ADDR;
  assign is_led = address == `RAMIO_LED_ADDR;
  assign is_write = write_type != wr_none;
  assign is_read = read_type != rd_none;

  // requests to cache and uart leave in the accept cycle
  assign tx_start = accept && is_uart && is_write;
  assign tx_byte = data_in[7:0];

  always_comb begin
    cache_req = '0;
    if (accept && !is_io) begin
      cache_req.write = is_write;
      cache_req.read = is_read;
      cache_req.addr = address[`RAMIO_RAM_ADDR_BITS-1:0];
      case (write_type)
        wr_byte: begin
          cache_req.wdata = {24'b0, data_in[7:0]} << {address[1:0], 3'b000};
          cache_req.byte_en = 4'b0001 << address[1:0];
        end
        wr_half: begin
          cache_req.wdata = {16'b0, data_in[15:0]} << {address[1], 4'b0000};
          cache_req.byte_en = 4'b0011 << {address[1], 1'b0};
        end
        wr_word: begin
          cache_req.wdata = data_in;
          cache_req.byte_en = 4'b1111;
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= dec_idle;
      data_out_ready <= 1'b0;
      led <= 4'b0;
    end else begin
      data_out_ready <= 1'b0;
      case (state)
        dec_idle: if (accept) begin
          addr_lo_q <= address[1:0];
          rtype_q <= read_type;
          if (!is_io) begin
            state <= dec_ram;
          end else if (is_uart && is_write) begin
            state <= dec_uart;
          end else begin
            state <= dec_misc;                  // led or unmapped i/o
            if (is_led && is_write) led <= data_in[3:0];
          end
        end
        dec_ram: if (cache_done) begin
          data_out <= extend(cache_rdata, addr_lo_q, rtype_q);
          data_out_ready <= rtype_q != rd_none;
          state <= dec_idle;
        end
        dec_uart: if (!tx_busy) state <= dec_idle;  // held until stop bit ends
        dec_misc: begin
          data_out <= '0;
          data_out_ready <= rtype_q != rd_none;
          state <= dec_idle;
        end
        default: state <= dec_idle;
      endcase
    end
  end

endmodule

/* verilog/ramio_cache.sv */
`include "ramio_consts.svh"

module ramio_cache (
  input wire clk,
  input wire reset,
  input ramio_pkg::cache_req_t req,
  output logic done,
  output logic [31:0] rdata,
  output ramio_pkg::br_cmd_t br_cmd,
  input ramio_pkg::br_rsp_t br_rsp
);

  import ramio_pkg::*;

  localparam int unsigned IndexBits = `RAMIO_LINE_INDEX_BITS;
  localparam int unsigned OffsetBits = `RAMIO_LINE_OFFSET_BITS;
  localparam int unsigned TagBits = `RAMIO_RAM_ADDR_BITS - IndexBits - OffsetBits;
  localparam int unsigned Lines = 1 << IndexBits;
  localparam logic [3:0] CmdGap = 4'(`RAMIO_BR_CMD_GAP);

  // ------------------------------------------------------------------------
  // line storage
  // ------------------------------------------------------------------------
  logic [Lines-1:0] valid;
  logic [Lines-1:0] dirty;
  logic [TagBits-1:0] tags[Lines];
  logic [63:0] lines[Lines];

  cache_state_e state;
  cache_req_t req_q;
  logic [31:0] rdata_q;
  logic [3:0] gap_cnt;      // spacing between burst commands
  br_cmd_t cmd_q;

  logic [IndexBits-1:0] index;
  logic [TagBits-1:0] tag;
  logic hit;
  logic [63:0] fill_line;

  // write bytes of a request into a line
  function automatic logic [63:0] merge(input logic [63:0] line, input cache_req_t r);
    logic [63:0] res;
    int base;
    res = line;
    base = r.addr[2] ? 32 : 0;
    if (r.write) begin
      for (int i = 0; i < 4; i++) begin
        if (r.byte_en[i]) res[base + i * 8 +: 8] = r.wdata[i * 8 +: 8];
      end
    end
    return res;
  endfunction

  function automatic logic [31:0] word_of(input logic [63:0] line, input logic sel);
    return sel ? line[63:32] : line[31:0];
  endfunction

  assign index = req_q.addr[OffsetBits +: IndexBits];
  assign tag = req_q.addr[`RAMIO_RAM_ADDR_BITS-1 -: TagBits];
  assign hit = valid[index] && tags[index] == tag;
  assign fill_line = merge(br_rsp.rd_data, req_q);

  assign done = state == st_done;
  assign rdata = rdata_q;
  assign br_cmd = cmd_q;

  // ------------------------------------------------------------------------
  // fsm
  // ------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      valid <= '0;
      dirty <= '0;
      gap_cnt <= '0;
      cmd_q.cmd_en <= 1'b0;
      cmd_q.data_mask <= '0;              // full line writes only
    end else begin
      cmd_q.cmd_en <= 1'b0;
      if (gap_cnt != 4'd0) gap_cnt <= gap_cnt - 4'd1;
      case (state)
        st_idle: if (req.read || req.write) begin
          req_q <= req;
          state <= st_lookup;
        end
        st_lookup: begin
          if (hit) begin
            if (req_q.write) begin
              lines[index] <= merge(lines[index], req_q);
              dirty[index] <= 1'b1;
            end
            rdata_q <= word_of(lines[index], req_q.addr[2]);
            state <= st_done;
          end else if (valid[index] && dirty[index]) begin
            state <= st_evict;
          end else begin
            state <= st_fill_req;
          end
        end
        st_evict: if (gap_cnt == 4'd0) begin
          cmd_q.cmd <= 1'b1;                 // write back old line
          cmd_q.cmd_en <= 1'b1;
          cmd_q.addr <= {tags[index], index, OffsetBits'(0)};
          cmd_q.wr_data <= lines[index];
          dirty[index] <= 1'b0;
          gap_cnt <= CmdGap;
          state <= st_fill_req;
        end
        st_fill_req: if (gap_cnt == 4'd0) begin
          cmd_q.cmd <= 1'b0;
          cmd_q.cmd_en <= 1'b1;
          cmd_q.addr <= {tag, index, OffsetBits'(0)};
          gap_cnt <= CmdGap;
          state <= st_fill_wait;
        end
        st_fill_wait: if (br_rsp.rd_data_valid) begin
          lines[index] <= fill_line;
          tags[index] <= tag;
          valid[index] <= 1'b1;
          dirty[index] <= req_q.write;
          rdata_q <= word_of(fill_line, req_q.addr[2]);
          state <= st_done;
        end
        st_done: state <= st_idle;           // done pulse
        default: state <= st_idle;
      endcase
    end
  end

endmodule

/* verilog/ramio_uart_tx.sv */
`include "ramio_consts.svh"

module ramio_uart_tx #(
  parameter int unsigned ClocksPerBit = `RAMIO_UART_CLKS_PER_BIT
) (
  input wire clk,
  input wire reset,
  input wire start,
  input wire [7:0] data,
  output logic tx,
  output logic busy
);

  localparam int unsigned CountBits = $clog2(ClocksPerBit + 1);

  logic [CountBits-1:0] clk_cnt;
  logic [3:0] bit_cnt;      // 0 is start bit, 9 is stop bit
  logic [9:0] frame;

  // ------------------------------------------------------------------------
  // 8n1 shifter, lsb first
  // ------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      busy <= 1'b0;
      clk_cnt <= '0;
      bit_cnt <= 4'd0;
    end else if (!busy) begin
      if (start) begin
        frame <= {1'b1, data, 1'b0};
        busy <= 1'b1;
        clk_cnt <= '0;
        bit_cnt <= 4'd0;
      end
    end else if (clk_cnt == CountBits'(ClocksPerBit - 1)) begin
      clk_cnt <= '0;
      frame <= {1'b1, frame[9:1]};
      if (bit_cnt == 4'd9) begin
        busy <= 1'b0;                         // stop bit done
      end else begin
        bit_cnt <= bit_cnt + 4'd1;
      end
    end else begin
      clk_cnt <= clk_cnt + 1'b1;
    end
  end

  // line idles high
  assign tx = !busy || frame[0];

endmodule

/* verilog/ramio.sv */
module ramio (
  input wire clk,
  input wire reset,

  // core request port
  input wire enable,
  input ramio_pkg::write_type_e write_type,
  input ramio_pkg::read_type_e read_type,
  input wire [31:0] address,
  input wire [31:0] data_in,
  output logic [31:0] data_out,
  output logic data_out_ready,
  output logic busy,

  output logic [3:0] led,
  output logic uart_tx,

  // burst ram controller
  output ramio_pkg::br_cmd_t br_cmd,
  input ramio_pkg::br_rsp_t br_rsp
);

  import ramio_pkg::*;

  cache_req_t cache_req;
  logic cache_done;
  logic [31:0] cache_rdata;
  logic tx_start;
  logic [7:0] tx_byte;
  logic tx_busy;

  // ------------------------------------------------------------------------
  // request decoder
  // ------------------------------------------------------------------------
  ramio_decoder decoder (
    .clk,
    .reset,
    .enable,
    .write_type,
    .read_type,
    .address,
    .data_in,
    .data_out,
    .data_out_ready,
    .busy,
    .led,
    .cache_req,
    .cache_done,
    .cache_rdata,
    .tx_start,
    .tx_byte,
    .tx_busy
  );

  // ------------------------------------------------------------------------
  // cache in front of burst ram
  // ------------------------------------------------------------------------
  ramio_cache cache (
    .clk,
    .reset,
    .req(cache_req),
    .done(cache_done),
    .rdata(cache_rdata),
    .br_cmd,
    .br_rsp
  );

  // ------------------------------------------------------------------------
  // uart transmitter
  // ------------------------------------------------------------------------
  ramio_uart_tx uart (
    .clk,
    .reset,
    .start(tx_start),
    .data(tx_byte),
    .tx(uart_tx),
    .busy(tx_busy)
  );

endmodule

/* verif/burst_ram_model.sv */
`include "ramio_consts.svh"

module burst_ram_model (
  input wire clk,
  input wire reset,
  input ramio_pkg::br_cmd_t cmd,
  output ramio_pkg::br_rsp_t rsp
);

  import ramio_pkg::*;

  localparam int AW = `RAMIO_RAM_ADDR_BITS;
  localparam int OB = `RAMIO_LINE_OFFSET_BITS;
  localparam int ReadLatency = 5;

  logic [63:0] mem[logic [AW-1:0]];     // keyed by line base address
  logic [AW-1:0] pend_addr;
  int pend_cnt;

  // contents of a line that was never written
  function automatic logic [7:0] pattern_byte(input logic [AW-1:0] a);
    return a[7:0] ^ a[15:8] ^ 8'(a >> 16) ^ 8'h5c;
  endfunction

  function automatic logic [63:0] peek(input logic [AW-1:0] addr);
    logic [AW-1:0] base;
    logic [63:0] line;
    base = {addr[AW-1:OB], OB'(0)};
    if (mem.exists(base)) return mem[base];
    for (int i = 0; i < 8; i++) begin
      line[i * 8 +: 8] = pattern_byte(base + AW'(i));
    end
    return line;
  endfunction

  // one read outstanding at a time
  always @(posedge clk) begin
    rsp.rd_data_valid <= 1'b0;
    if (reset) begin
      pend_cnt <= 0;
    end else if (cmd.cmd_en && cmd.cmd) begin
      mem[{cmd.addr[AW-1:OB], OB'(0)}] = cmd.wr_data;
    end else if (cmd.cmd_en) begin
      pend_addr <= cmd.addr;
      pend_cnt <= ReadLatency;
    end else if (pend_cnt != 0) begin
      pend_cnt <= pend_cnt - 1;
      if (pend_cnt == 1) begin
        rsp.rd_data <= peek(pend_addr);
        rsp.rd_data_valid <= 1'b1;         // single beat per line
      end
    end
  end

endmodule

/* verif/ramio_tb.sv */
`include "ramio_consts.svh"

module ramio_tb;

  import ramio_pkg::*;

  localparam int AW = `RAMIO_RAM_ADDR_BITS;
  localparam int OB = `RAMIO_LINE_OFFSET_BITS;

  typedef enum logic [2:0] {op_write, op_read, op_uart, op_led, op_peek} op_e;

  typedef struct packed {
    op_e op;
    logic [31:0] addr;
    write_type_e wtype;
    read_type_e rtype;
    logic [31:0] data;
    logic [63:0] expected;
    logic [7:0] cycles;       // 0 when latency is not fixed
  } entry_t;

  logic clk;
  logic reset;
  logic enable;
  write_type_e write_type;
  read_type_e read_type;
  logic [31:0] address;
  logic [31:0] data_in;
  logic [31:0] data_out;
  logic data_out_ready;
  logic busy;
  logic [3:0] led;
  logic uart_tx;
  br_cmd_t br_cmd;
  br_rsp_t br_rsp;

  entry_t stim[$];
  logic [7:0] ref_mem[logic [AW-1:0]];   // expected byte contents of ram
  logic [31:0] lcg_state = 32'h5aad_29f3;
  logic stim_ready = 1'b0;
  int value_errors = 0;
  int other_errors = 0;
  int uart_frames = 0;
  logic [7:0] uart_byte;

  ramio uut (.clk, .reset, .enable, .write_type, .read_type, .address, .data_in,
    .data_out, .data_out_ready, .busy, .led, .uart_tx, .br_cmd, .br_rsp);

  burst_ram_model ram (.clk, .reset, .cmd(br_cmd), .rsp(br_rsp));

  always #4 clk = ~clk;

  // ------------------------------------------------------------------------
  // reference model and table building
  // ------------------------------------------------------------------------
  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [AW-1:0] word_addr();
    logic [31:0] r;
    r = next_rand();
    return {r[AW-1:2], 2'b00};
  endfunction

  function automatic logic [7:0] pattern_byte(input logic [AW-1:0] a);
    return a[7:0] ^ a[15:8] ^ 8'(a >> 16) ^ 8'h5c;
  endfunction

  function automatic logic [7:0] ref_byte(input logic [AW-1:0] a);
    return ref_mem.exists(a) ? ref_mem[a] : pattern_byte(a);
  endfunction

  // little endian, lowest address in bits 7..0
  function automatic logic [31:0] predict(input logic [AW-1:0] a, input read_type_e rt);
    logic [7:0] b;
    logic [15:0] h;
    b = ref_byte(a);
    h = {ref_byte(a + AW'(1)), b};
    case (rt)
      rd_byte: return {{24{b[7]}}, b};
      rd_byte_u: return {24'b0, b};
      rd_half: return {{16{h[15]}}, h};
      rd_half_u: return {16'b0, h};
      default: return {ref_byte(a + AW'(3)), ref_byte(a + AW'(2)), h};
    endcase
  endfunction

  task automatic add_write(input logic [AW-1:0] a, input write_type_e wt,
                           input logic [31:0] d, input logic [7:0] cyc);
    int n;
    n = (wt == wr_byte) ? 1 : (wt == wr_half) ? 2 : 4;
    for (int i = 0; i < n; i++) begin
      ref_mem[a + AW'(i)] = d[i * 8 +: 8];
    end
    stim.push_back(entry_t'{op_write, 32'(a), wt, rd_none, d, 64'b0, cyc});
  endtask

  task automatic add_read(input logic [AW-1:0] a, input read_type_e rt, input logic [7:0] cyc);
    stim.push_back(entry_t'{op_read, 32'(a), wr_none, rt, 32'b0, 64'(predict(a, rt)), cyc});
  endtask

  task automatic add_peek(input logic [AW-1:0] a);
    logic [AW-1:0] base;
    logic [63:0] line;
    base = {a[AW-1:OB], OB'(0)};
    for (int i = 0; i < 8; i++) begin
      line[i * 8 +: 8] = ref_byte(base + AW'(i));
    end
    stim.push_back(entry_t'{op_peek, 32'(a), wr_none, rd_none, 32'b0, line, 8'd0});
  endtask

  task automatic build_stim();
    logic [AW-1:0] a;
    logic [31:0] d;
    for (int i = 0; i < 6; i++) begin
      a = word_addr();
      add_write(a, wr_word, next_rand(), 8'd0);
      add_read(a, rd_word, 8'd3);
      add_read(a, rd_word, 8'd3);
    end
    add_read(word_addr(), rd_word, 8'd0);      // cold line, fill pattern
    for (int i = 0; i < 2; i++) begin
      a = word_addr();
      add_write(a, wr_word, next_rand(), 8'd0);
      add_write(a + AW'(1), wr_byte, next_rand() | 32'h80, 8'd3);   // negative byte
      add_write(a + AW'(2), wr_half, next_rand() | 32'h8000, 8'd3);
      add_read(a + AW'(1), rd_byte, 8'd3);
      add_read(a + AW'(1), rd_byte_u, 8'd3);
      add_read(a + AW'(2), rd_half, 8'd3);
      add_read(a + AW'(2), rd_half_u, 8'd3);
      add_read(a, rd_half, 8'd3);
      add_read(a + AW'(3), rd_byte, 8'd3);
      add_read(a, rd_word, 8'd3);
    end
    // same index, different tag
    a = word_addr();
    add_write(a, wr_word, next_rand(), 8'd0);
    add_write(a ^ AW'(128), wr_word, next_rand(), 8'd0);
    add_read(a, rd_word, 8'd0);
    add_peek(a);
    d = next_rand();
    stim.push_back(entry_t'{op_uart, `RAMIO_UART_ADDR, wr_byte, rd_none, d, 64'(d[7:0]),
                            8'(10 * `RAMIO_UART_CLKS_PER_BIT + 2)});   // ten bit times
    d = next_rand();
    stim.push_back(entry_t'{op_led, `RAMIO_LED_ADDR, wr_byte, rd_none, d, 64'(d[3:0]), 8'd2});
  endtask

  // ------------------------------------------------------------------------
  // checks and driving
  // ------------------------------------------------------------------------
  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    assert (act === exp) else begin
      $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
      value_errors++;
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond) else begin
      $display("Failure at %0t: %s", $time, what);
      other_errors++;
    end
  endtask

  // cycles counted from the edge that raises enable
  task automatic run_access(input entry_t e, output int cycles);
    @(posedge clk);
    enable <= 1'b1;
    address <= e.addr;
    data_in <= e.data;
    write_type <= e.wtype;
    read_type <= e.rtype;
    @(posedge clk);
    enable <= 1'b0;
    write_type <= wr_none;
    read_type <= rd_none;
    cycles = 1;
    @(negedge clk);
    while (busy) begin
      @(negedge clk);
      cycles++;
    end
  endtask

  // serial line decoder, samples mid bit
  initial begin
    logic [7:0] bits;
    @(negedge reset);
    forever begin
      @(negedge uart_tx);
      repeat (`RAMIO_UART_CLKS_PER_BIT / 2) @(negedge clk);
      check_true(uart_tx == 1'b0, "uart start bit was not low in its middle");
      for (int i = 0; i < 8; i++) begin
        repeat (`RAMIO_UART_CLKS_PER_BIT) @(negedge clk);
        bits[i] = uart_tx;
      end
      repeat (`RAMIO_UART_CLKS_PER_BIT) @(negedge clk);
      check_true(uart_tx == 1'b1, "uart stop bit was not high");
      uart_byte = bits;
      uart_frames++;
    end
  end

  initial begin
    wait (stim_ready);
    repeat (stim.size() * 400 + 2000) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles", stim.size() * 400 + 2000);
    $display("Checks failed");
    $finish;
  end

  initial begin
    entry_t e;
    int cycles;
    int frames_before;
    clk = 1'b0;
    reset = 1'b1;
    enable = 1'b0;
    write_type = wr_none;
    read_type = rd_none;
    address = 32'b0;
    data_in = 32'b0;
    build_stim();
    stim_ready = 1'b1;
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check_value("busy", 64'(0), 64'(busy));
    check_value("data_out_ready", 64'(0), 64'(data_out_ready));
    check_value("br_cmd.cmd_en", 64'(0), 64'(br_cmd.cmd_en));
    check_value("uart_tx", 64'(1), 64'(uart_tx));
    check_value("led", 64'(0), 64'(led));

    foreach (stim[i]) begin
      e = stim[i];
      if (e.op == op_peek) begin
        check_value("ram line", e.expected, ram.peek(e.addr[AW-1:0]));
      end else begin
        frames_before = uart_frames;
        run_access(e, cycles);
        if (e.op == op_read) begin
          check_value("data_out_ready", 64'(1), 64'(data_out_ready));
          check_value("data_out", e.expected, 64'(data_out));
        end else begin
          check_value("data_out_ready", 64'(0), 64'(data_out_ready));
        end
        if (e.cycles != 8'd0) check_value("access cycles", 64'(e.cycles), 64'(cycles));
        if (e.op == op_uart) begin
          check_true(uart_frames == frames_before + 1, "no complete uart frame was seen");
          check_value("uart byte", e.expected, 64'(uart_byte));
        end
        if (e.op == op_led) check_value("led", e.expected, 64'(led));
      end
    end

    $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

/* ramio.f */
+incdir+include
verilog/ramio_pkg.sv
verilog/ramio_decoder.sv
verilog/ramio_cache.sv
verilog/ramio_uart_tx.sv
verilog/ramio.sv
verif/burst_ram_model.sv
verif/ramio_tb.sv

/* Makefile */
TOP = ramio_tb

.PHONY: all lint clean

# build and run, then look for the pass line in the log
all:
	verilator --binary --timing -Wno-fatal -f ramio.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^All checks passed$$" sim.log

lint:
	verilator --lint-only --timing -Wall -f ramio.f --top-module ramio

clean:
	rm -rf obj_dir sim.log
